// File: verilog/floor_pattern.svh
/* Ground texture, four rows of 128 pixels repeating along the floor */
`ifndef FLOOR_PATTERN_SVH
`define FLOOR_PATTERN_SVH

localparam logic [127:0] FLOOR_PATTERN [TEXTURE_ROWS] = '{
    128'h0000_0000_0000_0000_0000_E000_0000_0000,   // Row at FLOOR_Y
    128'hFFFF_FFFF_FFFF_FFFF_FFFF_3E3F_FFFF_FFFF,   // Bright ground line with a gap
    128'h0000_0000_0000_0000_0000_03E0_0000_0000,
    128'h0080_0200_0360_4004_0000_0408_0100_0002    // Scattered pebbles
};

`endif

// File: verilog/render_pkg.sv
/* Render geometry package
   Screen layout, sprite sizes and the pixel position struct */

package render_pkg;

    // Screen and ground
    localparam int SCREEN_W     = 640;   // Obstacles enter at the right edge
    localparam int FLOOR_Y      = 240;   // First ground row
    localparam int TEXTURE_ROWS = 4;     // Textured rows starting at FLOOR_Y

    // Goose placement, fixed column, height set by the jump
    localparam int GOOSE_X      = 50;
    localparam int GOOSE_Y_BASE = 200;   // Top row when standing on the ground
    localparam int GOOSE_W      = 30;
    localparam int GOOSE_H      = 40;

    // Tram obstacle, sits on the floor
    localparam int TRAM_W       = 30;
    localparam int TRAM_H       = 40;

    // Controller side widths
    localparam int SCROLL_W     = 11;    // World scroll position
    localparam int JUMP_W       = 7;     // Jump height above the ground

    // Current beam position
    typedef struct packed {
        logic [9:0] haddr;   // Column
        logic [9:0] vaddr;   // Row
    } pix_pos_t;

endpackage

// File: verilog/color_pkg.sv
/* Colour package
   RGB222 pixel types, background palette and sprite part codes */

package color_pkg;

    typedef struct packed {
        logic [1:0] r;
        logic [1:0] g;
        logic [1:0] b;
    } rgb_t;

    // One sprite layer sample
    typedef struct packed {
        logic hit;   // Sprite covers this pixel
        rgb_t rgb;
    } sprite_px_t;

    localparam rgb_t SKY_RGB     = '{r: 2'd0, g: 2'd3, b: 2'd3};
    localparam rgb_t FLOOR_RGB   = '{r: 2'd1, g: 2'd1, b: 2'd1};
    localparam rgb_t TEXTURE_RGB = '{r: 2'd3, g: 2'd3, b: 2'd3};
    localparam rgb_t DEAD_RGB    = '{r: 2'd3, g: 2'd0, b: 2'd0};   // Goose after a crash
    localparam rgb_t BLACK_RGB   = '{r: 2'd0, g: 2'd0, b: 2'd0};

    // Goose regions, listed in match order
    typedef enum logic [3:0] {
        GOOSE_NONE, GOOSE_BEAK, GOOSE_EYE, GOOSE_CHEEK, GOOSE_BELLY, GOOSE_HEAD,
        GOOSE_NECK, GOOSE_WING_EDGE, GOOSE_LEGS, GOOSE_TAIL, GOOSE_WING, GOOSE_BODY
    } goose_part_t;

    // Tram front view regions, listed in match order
    typedef enum logic [3:0] {
        TRAM_NONE, TRAM_HEADLIGHT, TRAM_COUPLER, TRAM_BLADE, TRAM_GLASS,
        TRAM_BODY, TRAM_ROOF_BOX, TRAM_ROOF, TRAM_SHADOW
    } tram_part_t;

endpackage

// File: verilog/goose_sprite.sv
/* Goose sprite layer
   Maps the pixel to a goose part and registers hit and colour */
`timescale 1ns/1ns

module goose_sprite import render_pkg::*, color_pkg::*; (
    input  logic              clk,
    input  logic              sys_rst,
    input  logic              display_on,
    input  pix_pos_t          pos,
    input  logic [JUMP_W-1:0] jump_pos,
    input  logic              game_over,
    input  logic              game_start_blink,
    output sprite_px_t        goose_px
);

    logic [10:0] goose_y;   // Top row, rises with the jump
    logic [10:0] h_ext;
    logic [10:0] v_ext;
    logic        in_box;
    logic [4:0]  loc_x;
    logic [5:0]  loc_y;
    goose_part_t part;
    logic        hit_q;
    rgb_t        rgb_q;

    // First match wins, small details before the large areas
    function automatic goose_part_t classify_goose(input logic [4:0] x, input logic [5:0] y);
        logic [5:0]  xx;
        logic [5:0]  wing_lo;
        logic [5:0]  neck_lo;
        goose_part_t p;

        xx = {1'b0, x};
        // Left edge of the raised wing, rows 14 to 24
        wing_lo = (y <= 6'd15) ? 6'd6 : (y <= 6'd19) ? y - 6'd9 : 6'd10;
        // Neck shifts left by one every two rows
        neck_lo = 6'd20 - ((y - 6'd17) >> 1);

        if (y >= 13 && y <= 14 && xx >= 27 && xx <= 28)
            p = GOOSE_BEAK;
        else if (y >= 12 && y <= 13 && xx == 24)
            p = GOOSE_EYE;
        else if (y >= 13 && y <= 14 && xx >= 22 && xx <= 23)
            p = GOOSE_CHEEK;
        else if (y >= 34 && y <= 35 && xx >= 12 && xx <= 18)
            p = GOOSE_BELLY;
        else if (y >= 11 && y <= 16 && xx >= 22 && xx <= 26)
            p = GOOSE_HEAD;
        else if (y >= 17 && y <= 24 && (xx == neck_lo || xx == neck_lo + 6'd1))
            p = GOOSE_NECK;
        else if (y >= 14 && y <= 24 && xx == wing_lo)
            p = GOOSE_WING_EDGE;
        else if (y >= 36 && y <= 39 && (xx == 12 || xx == 15))
            p = GOOSE_LEGS;
        else if ((y >= 29 && y <= 34 && xx >= 6 && xx <= 7) ||
                 ((y == 32 || y == 33) && xx == 8))
            p = GOOSE_TAIL;
        else if (y >= 14 && y <= 24 && xx >= wing_lo && xx <= y - 6'd6)
            p = GOOSE_WING;
        else if ((y >= 25 && y <= 28 && xx >= 10 && xx <= 22) ||
                 (y >= 29 && y <= 32 && xx >= 9 && xx <= 22) ||
                 (y >= 33 && y <= 35 && xx >= 9 && xx <= 21))
            p = GOOSE_BODY;
        else
            p = GOOSE_NONE;
        return p;
    endfunction

    assign goose_y = 11'(GOOSE_Y_BASE) - {4'd0, jump_pos};
    assign h_ext   = {1'b0, pos.haddr};
    assign v_ext   = {1'b0, pos.vaddr};

    assign in_box = (h_ext >= 11'(GOOSE_X)) && (h_ext < 11'(GOOSE_X + GOOSE_W)) &&
                    (v_ext >= goose_y) && (v_ext < goose_y + 11'(GOOSE_H));

    // Sprite local coordinates, only meaningful inside the box
    assign loc_x = 5'(h_ext - 11'(GOOSE_X));
    assign loc_y = 6'(v_ext - goose_y);
    assign part  = classify_goose(loc_x, loc_y);

    always_ff @(posedge clk) begin
        if (sys_rst) begin
            hit_q <= 1'b0;
        end else begin
            // Blink hides the goose on the start screen
            hit_q <= in_box && (part != GOOSE_NONE) && game_start_blink && display_on;
        end
    end

    // Part to colour lookup
    always_ff @(posedge clk) begin
        if (game_over) begin
            rgb_q <= DEAD_RGB;
        end else begin
            case (part)
                GOOSE_BEAK:                  rgb_q <= '{r: 2'd3, g: 2'd2, b: 2'd1};
                GOOSE_EYE, GOOSE_CHEEK,
                GOOSE_BELLY:                 rgb_q <= '{r: 2'd3, g: 2'd3, b: 2'd3};
                GOOSE_HEAD, GOOSE_NECK,
                GOOSE_WING_EDGE, GOOSE_LEGS: rgb_q <= BLACK_RGB;
                GOOSE_TAIL:                  rgb_q <= '{r: 2'd2, g: 2'd1, b: 2'd0};
                GOOSE_WING, GOOSE_BODY:      rgb_q <= '{r: 2'd2, g: 2'd2, b: 2'd1};
                default:                     rgb_q <= BLACK_RGB;
            endcase
        end
    end

    assign goose_px = '{hit: hit_q, rgb: rgb_q};

endmodule

// File: verilog/tram_sprite.sv
/* Tram obstacle layer
   Places the tram from the scroll position, registers hit and colour */
`timescale 1ns/1ns

module tram_sprite import render_pkg::*, color_pkg::*; (
    input  logic                clk,
    input  logic                sys_rst,
    input  logic                display_on,
    input  pix_pos_t            pos,
    input  logic [SCROLL_W-1:0] scrolladdr,
    input  logic                tram_enable,
    output sprite_px_t          tram_px
);

    logic [10:0] tram_x;   // Left edge, moves left as the world scrolls
    logic [10:0] h_ext;
    logic [10:0] v_ext;
    logic        in_box;
    logic [4:0]  loc_x;
    logic [5:0]  loc_y;
    tram_part_t  part;
    logic        hit_q;
    rgb_t        rgb_q;

    function automatic tram_part_t classify_tram(input logic [4:0] x, input logic [5:0] y);
        tram_part_t p;

        if (y == 26 && ((x >= 8 && x <= 10) || (x >= 20 && x <= 22)))
            p = TRAM_HEADLIGHT;
        else if (y >= 30 && y <= 34 && x >= 14 && x <= 16)
            p = TRAM_COUPLER;
        else if (y >= 8 && y <= 28 && ((x >= 3 && x <= 4) || (x >= 25 && x <= 26)))
            p = TRAM_BLADE;   // Blue side accents
        else if (y >= 6 && y <= 24 && x >= 5 && x <= 24)
            p = TRAM_GLASS;
        else if (y >= 25 && y <= 39 && x >= 4 && x <= 26)
            p = TRAM_BODY;
        else if (y >= 2 && y <= 4 && x >= 12 && x <= 17)
            p = TRAM_ROOF_BOX;   // Pantograph base
        else if (y <= 5 && x >= 5 && x <= 24)
            p = TRAM_ROOF;
        else if (y == 39 && x >= 5 && x <= 24)
            p = TRAM_SHADOW;
        else
            p = TRAM_NONE;
        return p;
    endfunction

    assign tram_x = 11'(SCREEN_W) - scrolladdr;
    assign h_ext  = {1'b0, pos.haddr};
    assign v_ext  = {1'b0, pos.vaddr};

    assign in_box = (h_ext >= tram_x) && (h_ext < tram_x + 11'(TRAM_W)) &&
                    (v_ext >= 11'(FLOOR_Y - TRAM_H)) && (v_ext < 11'(FLOOR_Y));

    assign loc_x = 5'(h_ext - tram_x);
    assign loc_y = 6'(v_ext - 11'(FLOOR_Y - TRAM_H));
    assign part  = classify_tram(loc_x, loc_y);

    always_ff @(posedge clk) begin
        if (sys_rst) begin
            hit_q <= 1'b0;
        end else begin
            hit_q <= in_box && (part != TRAM_NONE) && tram_enable && display_on;
        end
    end

    always_ff @(posedge clk) begin
        case (part)
            TRAM_HEADLIGHT, TRAM_BODY: rgb_q <= '{r: 2'd3, g: 2'd3, b: 2'd3};
            TRAM_COUPLER:              rgb_q <= '{r: 2'd0, g: 2'd0, b: 2'd1};
            TRAM_BLADE, TRAM_ROOF:     rgb_q <= '{r: 2'd0, g: 2'd1, b: 2'd3};   // Line blue
            TRAM_ROOF_BOX:             rgb_q <= '{r: 2'd2, g: 2'd2, b: 2'd2};
            TRAM_SHADOW:               rgb_q <= '{r: 2'd1, g: 2'd1, b: 2'd1};
            default:                   rgb_q <= BLACK_RGB;   // Glass
        endcase
    end

    assign tram_px = '{hit: hit_q, rgb: rgb_q};

endmodule

// File: verilog/floor_layer.sv
/* Floor and sky layer
   Registers the sky, solid floor and scrolling texture flags */
`timescale 1ns/1ns

module floor_layer import render_pkg::*; (
    input  logic                clk,
    input  logic                sys_rst,
    input  logic                display_on,
    input  pix_pos_t            pos,
    input  logic [SCROLL_W-1:0] scrolladdr,
    output logic                sky,
    output logic                floor,
    output logic                texture
);

`include "floor_pattern.svh"

    logic [10:0]                     scroll_sum;
    logic [6:0]                      tex_idx;
    logic [$clog2(TEXTURE_ROWS)-1:0] tex_row;
    logic                            in_band;   // Inside the textured strip

    // Texture slides left as the world scrolls
    assign scroll_sum = {1'b0, pos.haddr} + scrolladdr;
    assign tex_idx    = scroll_sum[6:0];
    assign tex_row    = $clog2(TEXTURE_ROWS)'(pos.vaddr - 10'(FLOOR_Y));

    assign in_band = (pos.vaddr >= 10'(FLOOR_Y)) &&
                     (pos.vaddr < 10'(FLOOR_Y + TEXTURE_ROWS));

    always_ff @(posedge clk) begin
        if (sys_rst) begin
            sky     <= 1'b0;
            floor   <= 1'b0;
            texture <= 1'b0;
        end else begin
            sky     <= display_on && (pos.vaddr < 10'(FLOOR_Y));
            floor   <= display_on && (pos.vaddr >= 10'(FLOOR_Y));
            texture <= display_on && in_band && FLOOR_PATTERN[tex_row][tex_idx];
        end
    end

endmodule

// File: verilog/layer_compositor.sv
/* Layer compositor
   Picks the top visible layer, blanks the screen and flags collisions */
`timescale 1ns/1ns

module layer_compositor import color_pkg::*; (
    input  logic       display_on,
    input  sprite_px_t goose_px,
    input  sprite_px_t tram_px,
    input  logic       sky,
    input  logic       floor,
    input  logic       texture,
    output logic [1:0] r,
    output logic [1:0] g,
    output logic [1:0] b,
    output logic       collision
);

    rgb_t layer_rgb;
    rgb_t pix_rgb;

    // Goose over tram over texture over floor over sky
    always_comb begin
        if (goose_px.hit) begin
            layer_rgb = goose_px.rgb;
        end else if (tram_px.hit) begin
            layer_rgb = tram_px.rgb;
        end else if (texture) begin
            layer_rgb = TEXTURE_RGB;
        end else if (floor) begin
            layer_rgb = FLOOR_RGB;
        end else if (sky) begin
            layer_rgb = SKY_RGB;
        end else begin
            layer_rgb = BLACK_RGB;
        end
    end

    // Live blanking outside the visible area
    assign pix_rgb = display_on ? layer_rgb : BLACK_RGB;

    assign r = pix_rgb.r;
    assign g = pix_rgb.g;
    assign b = pix_rgb.b;

    assign collision = goose_px.hit & tram_px.hit;   // Same pixel covered by both

endmodule

// File: verilog/rendering.sv
/* Goose runner pixel renderer
   Sprite, floor and compositor layers, one clock from position to colour */
`timescale 1ns/1ns

module rendering import render_pkg::*, color_pkg::*; (
    input  logic                clk,
    input  logic                sys_rst,
    input  logic                display_on,
    input  logic [9:0]          haddr,
    input  logic [9:0]          vaddr,
    input  logic [SCROLL_W-1:0] scrolladdr,
    input  logic [JUMP_W-1:0]   jump_pos,
    input  logic                tram_enable,
    input  logic                game_over,
    input  logic                game_start_blink,
    output logic [1:0]          r,
    output logic [1:0]          g,
    output logic [1:0]          b,
    output logic                collision
);

    pix_pos_t   pos;
    sprite_px_t goose_px;
    sprite_px_t tram_px;
    logic       sky;
    logic       floor;
    logic       texture;

    assign pos = '{haddr: haddr, vaddr: vaddr};

    goose_sprite i_goose_sprite (
        .clk, .sys_rst, .display_on, .pos, .jump_pos,
        .game_over, .game_start_blink, .goose_px
    );

    tram_sprite i_tram_sprite (
        .clk, .sys_rst, .display_on, .pos, .scrolladdr, .tram_enable, .tram_px
    );

    floor_layer i_floor_layer (
        .clk, .sys_rst, .display_on, .pos, .scrolladdr, .sky, .floor, .texture
    );

    // Combinational, so all layers share the one clock of latency
    layer_compositor i_layer_compositor (
        .display_on, .goose_px, .tram_px, .sky, .floor, .texture,
        .r, .g, .b, .collision
    );

endmodule

// File: dv/render_tests.svh
/* Directed renderer tests, included in the testbench module */
`ifndef RENDER_TESTS_SVH
`define RENDER_TESTS_SVH

    task automatic test_reset_blank();
        // Overlap pixel is live, only the reset keeps every layer clear
        check_pixel("reset", BLACK_RGB, 1'b0);
        // Same overlap pixel, but the screen is blanked
        display_on = 1'b0;
        hold_pixel();
        check_pixel("blank overlap", BLACK_RGB, 1'b0);
        set_pixel(10, 10);
        hold_pixel();
        check_pixel("blank sky", BLACK_RGB, 1'b0);
    endtask

    task automatic test_background();
        int h;
        int v;

        display_on  = 1'b1;
        tram_enable = 1'b0;
        jump_pos    = 7'd0;
        scrolladdr  = 11'd0;
        for (int i = 0; i < 8; i++) begin
            h = $unsigned($random(seed)) % 640;
            v = $unsigned($random(seed)) % 200;   // Above the goose top
            set_pixel(h, v);
            hold_pixel();
            check_pixel("background sky", SKY_RGB, 1'b0);
        end
        for (int i = 0; i < 8; i++) begin
            h = $unsigned($random(seed)) % 640;
            v = 250 + $unsigned($random(seed)) % 230;
            set_pixel(h, v);
            hold_pixel();
            check_pixel("background floor", FLOOR_RGB, 1'b0);
        end
        // haddr plus scroll is 128, index 0 of the texture rows
        scrolladdr = 11'd100;
        set_pixel(28, FLOOR_Y + 1);
        hold_pixel();
        check_pixel("texture row 1", TEXTURE_RGB, 1'b0);
        set_pixel(28, FLOOR_Y);
        hold_pixel();
        check_pixel("texture row 0", FLOOR_RGB, 1'b0);
    endtask

    task automatic test_goose_parts();
        int jumps [2];
        int top;

        jumps            = '{0, 30};
        display_on       = 1'b1;
        tram_enable      = 1'b0;
        scrolladdr       = 11'd0;
        for (int i = 0; i < 2; i++) begin
            jump_pos = 7'(jumps[i]);
            top      = GOOSE_Y_BASE - jumps[i];   // Goose rises with the jump
            game_over        = 1'b0;
            game_start_blink = 1'b1;
            set_pixel(GOOSE_X + 27, top + 13);
            hold_pixel();
            check_pixel("goose beak", BEAK_RGB, 1'b0);
            set_pixel(GOOSE_X + 15, top + 26);
            hold_pixel();
            check_pixel("goose body", BODY_RGB, 1'b0);
            game_over = 1'b1;
            set_pixel(GOOSE_X + 27, top + 13);
            hold_pixel();
            check_pixel("dead beak", DEAD_RGB, 1'b0);
            set_pixel(GOOSE_X + 15, top + 26);
            hold_pixel();
            check_pixel("dead body", DEAD_RGB, 1'b0);
            game_over        = 1'b0;
            game_start_blink = 1'b0;
            set_pixel(GOOSE_X + 27, top + 13);
            hold_pixel();
            check_pixel("blink beak", SKY_RGB, 1'b0);
            set_pixel(GOOSE_X + 15, top + 26);
            hold_pixel();
            check_pixel("blink body", SKY_RGB, 1'b0);
        end
    endtask

    task automatic test_tram();
        display_on       = 1'b1;
        jump_pos         = 7'd0;
        game_start_blink = 1'b0;
        scrolladdr       = 11'd300;   // Left edge at 340
        tram_enable      = 1'b1;
        set_pixel(340 + 9, 200 + 26);
        hold_pixel();
        check_pixel("tram headlight", WHITE_RGB, 1'b0);
        set_pixel(340 + 10, 200 + 10);
        hold_pixel();
        check_pixel("tram glass", BLACK_RGB, 1'b0);
        tram_enable = 1'b0;
        set_pixel(340 + 9, 200 + 26);
        hold_pixel();
        check_pixel("tram off headlight", SKY_RGB, 1'b0);
        set_pixel(340 + 10, 200 + 10);
        hold_pixel();
        check_pixel("tram off glass", SKY_RGB, 1'b0);
    endtask

    task automatic test_collision();
        display_on       = 1'b1;
        scrolladdr       = 11'd580;   // Tram left edge at 60
        jump_pos         = 7'd0;
        tram_enable      = 1'b1;
        game_over        = 1'b0;
        game_start_blink = 1'b1;
        set_pixel(70, 226);
        hold_pixel();
        check_pixel("collision overlap", BODY_RGB, 1'b1);
        set_pixel(85, 226);
        hold_pixel();
        check_pixel("collision tram only", LINE_BLUE_RGB, 1'b0);
        jump_pos = 7'd50;
        set_pixel(70, 226);
        hold_pixel();
        check_pixel("collision jumped", WHITE_RGB, 1'b0);   // Goose clears the tram
    endtask

`endif

// File: dv/tb_rendering.sv
/* Testbench for the goose runner pixel renderer
   Clock, reset, DUT, value checks, watchdog and the directed test sequence */
`timescale 1ns/1ns

module tb_rendering import render_pkg::*, color_pkg::*; ();

    localparam int CLK_PERIOD   = 10;
    localparam int NUM_TESTS    = 5;
    localparam int TIMEOUT_CLKS = NUM_TESTS * 200;   // Generous per-test budget

    // Sprite colours from the part tables
    localparam rgb_t BEAK_RGB      = '{r: 2'd3, g: 2'd2, b: 2'd1};
    localparam rgb_t BODY_RGB      = '{r: 2'd2, g: 2'd2, b: 2'd1};
    localparam rgb_t WHITE_RGB     = '{r: 2'd3, g: 2'd3, b: 2'd3};
    localparam rgb_t LINE_BLUE_RGB = '{r: 2'd0, g: 2'd1, b: 2'd3};

    logic                clk;
    logic                sys_rst;
    logic                display_on;
    logic [9:0]          haddr;
    logic [9:0]          vaddr;
    logic [SCROLL_W-1:0] scrolladdr;
    logic [JUMP_W-1:0]   jump_pos;
    logic                tram_enable;
    logic                game_over;
    logic                game_start_blink;
    logic [1:0]          r;
    logic [1:0]          g;
    logic [1:0]          b;
    logic                collision;

    integer seed;

    rendering i_rendering (
        .clk              (clk),
        .sys_rst          (sys_rst),
        .display_on       (display_on),
        .haddr            (haddr),
        .vaddr            (vaddr),
        .scrolladdr       (scrolladdr),
        .jump_pos         (jump_pos),
        .tram_enable      (tram_enable),
        .game_over        (game_over),
        .game_start_blink (game_start_blink),
        .r                (r),
        .g                (g),
        .b                (b),
        .collision        (collision)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_eq(input string name, input logic [6:0] expected,
                            input logic [6:0] actual);
        if (actual !== expected) begin
            $display("ERR %s expected %0h actual %0h", name, expected, actual);
            $display("TESTS FAILED");
            $fatal(1, "Check %s failed", name);
        end
    endtask

    // Colour and collision of the current pixel
    task automatic check_pixel(input string name, input rgb_t exp_rgb, input logic exp_col);
        check_eq({name, " rgb"}, {1'b0, exp_rgb}, {1'b0, r, g, b});
        check_eq({name, " collision"}, {6'd0, exp_col}, {6'd0, collision});
    endtask

    task automatic set_pixel(input int h, input int v);
        haddr = 10'(h);
        vaddr = 10'(v);
    endtask

    // Inputs held for two clocks, sampled just after the edge
    task automatic hold_pixel();
        repeat (2) @(posedge clk);
        #1;
    endtask

`include "render_tests.svh"

    initial begin
        #(TIMEOUT_CLKS * CLK_PERIOD);
        $display("Watchdog timeout, the tests did not finish in time");
        $display("TESTS FAILED");
        $fatal(1, "Simulation timed out");
    end

    initial begin
        clk              = 1'b0;
        sys_rst          = 1'b1;
        // Goose and tram overlap on a visible pixel while reset is held
        display_on       = 1'b1;
        haddr            = 10'd70;
        vaddr            = 10'd226;
        scrolladdr       = 11'd580;
        jump_pos         = 7'd0;
        tram_enable      = 1'b1;
        game_over        = 1'b0;
        game_start_blink = 1'b1;
        seed             = 32'h125c_9c1b;

        repeat (3) @(posedge clk);
        #1;
        sys_rst = 1'b0;

        test_reset_blank();
        test_background();
        test_goose_parts();
        test_tram();
        test_collision();

        $display("TESTS PASSED");
        $finish;
    end

endmodule

// File: files.f
+incdir+verilog
+incdir+dv
verilog/render_pkg.sv
verilog/color_pkg.sv
verilog/goose_sprite.sv
verilog/tram_sprite.sv
verilog/floor_layer.sv
verilog/layer_compositor.sv
verilog/rendering.sv
dv/tb_rendering.sv

// File: run_sim.sh
#!/bin/sh
# Build the renderer testbench with Verilator, run it, and judge the result from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary --timing --top-module tb_rendering -f files.f -o sim_rendering \
    > build.log 2>&1 &&
./obj_dir/sim_rendering > sim.log 2>&1 ||
echo "Build or simulation ended with an error, see build.log and sim.log"

grep -q "TESTS PASSED" sim.log 2>/dev/null && echo "Result: pass" ||
{ echo "Result: fail"; exit 1; }
